// File: rtl/pe_pkg.sv
package pe_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // node address, also indexes the instruction store
  localparam int NODE_W = 8;
  // generation (colour) of a token
  localparam int GEN_W = 12;
  localparam int DATA_W = 32;
  localparam int IMM_W = 16;
  // default matching memory index width
  localparam int MM_ADDR_W = 4;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MUL  = 3'd5,
    OP_LT   = 3'd6,
    OP_PASS = 3'd7
  } opcode_e;

  //////////////////////////////////////////////////
  // stream payloads
  //////////////////////////////////////////////////

  // lr: 0 left, 1 right
  typedef struct packed {
    logic [NODE_W-1:0] node;
    logic [GEN_W-1:0]  gen;
    logic [DATA_W-1:0] opr;
    logic              lr;
    logic              uni;
  } token_t;

  // fired operands, left always in opr0
  // uni marks a single-operand firing, so execute can swap in the immediate
  typedef struct packed {
    logic [NODE_W-1:0] node;
    logic [GEN_W-1:0]  gen;
    logic              uni;
    logic [DATA_W-1:0] opr0;
    logic [DATA_W-1:0] opr1;
  } pair_t;

  // ext 1 sends the result to the ICN, 0 loops it back
  typedef struct packed {
    opcode_e           op;
    logic [NODE_W-1:0] dest_node;
    logic              dest_lr;
    logic              dest_uni;
    logic              ext;
    logic [IMM_W-1:0]  imm;
  } instr_t;

  typedef struct packed {
    pair_t  pair;
    instr_t instr;
  } fetched_t;

endpackage

// File: rtl/token_merge.sv
`timescale 1ns/1ns
module token_merge (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           ext_send_i,
  input  pe_pkg::token_t ext_tok_i,
  input  logic           loop_send_i,
  input  pe_pkg::token_t loop_tok_i,
  input  logic           out_ack_i,
  output logic           ext_ack_o,
  output logic           loop_ack_o,
  output logic           out_send_o,
  output pe_pkg::token_t out_tok_o
);

  logic room;
  logic take;

  // output slot free, or drained this cycle
  assign room = !out_send_o || out_ack_i;

  // loopback wins so loops drain first
  assign loop_ack_o = room && loop_send_i;
  assign ext_ack_o  = room && !loop_send_i;

  assign take = (loop_send_i || ext_send_i) && room;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_send_o <= 1'b0;
    end else if (take) begin
      out_send_o <= 1'b1;
    end else if (out_ack_i) begin
      out_send_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_tok_o <= loop_send_i ? loop_tok_i : ext_tok_i;
    end
  end

endmodule

// File: rtl/firing_match.sv
`timescale 1ns/1ns
module firing_match #(
  parameter int MM_ADDR_W = pe_pkg::MM_ADDR_W
) (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           in_send_i,
  input  pe_pkg::token_t in_tok_i,
  input  logic           out_ack_i,
  output logic           in_ack_o,
  output logic           out_send_o,
  output pe_pkg::pair_t  out_pair_o,
  output logic           overflow_o
);

  localparam int DEPTH = 2 ** MM_ADDR_W;

  // waiting operand, valid bit kept apart
  typedef struct packed {
    logic [pe_pkg::NODE_W-1:0] node;
    logic [pe_pkg::GEN_W-1:0]  gen;
    logic                      lr;
    logic [pe_pkg::DATA_W-1:0] opr;
  } mm_entry_t;

  logic [DEPTH-1:0]     mm_vld;
  mm_entry_t            mm_data [DEPTH];
  logic [MM_ADDR_W-1:0] slot;
  mm_entry_t            entry;
  logic                 hit;
  logic                 fire;
  logic                 take;
  logic                 store;
  pe_pkg::pair_t        pair_d;

  // slot picked by the low gen bits
  assign slot  = in_tok_i.gen[MM_ADDR_W-1:0];
  assign entry = mm_data[slot];

  assign hit = mm_vld[slot] && (entry.node == in_tok_i.node) &&
               (entry.gen == in_tok_i.gen) && (entry.lr != in_tok_i.lr);

  assign in_ack_o = !out_send_o || out_ack_i;
  assign take     = in_send_i && in_ack_o;
  assign fire     = in_tok_i.uni || hit;
  assign store    = take && !in_tok_i.uni && !mm_vld[slot];

  // order operands, left goes to opr0
  always_comb begin
    pair_d.node = in_tok_i.node;
    pair_d.gen  = in_tok_i.gen;
    pair_d.uni  = in_tok_i.uni;
    pair_d.opr0 = in_tok_i.opr;
    pair_d.opr1 = entry.opr;
    if (in_tok_i.uni) begin
      pair_d.opr1 = in_tok_i.opr;
    end else if (in_tok_i.lr) begin
      pair_d.opr0 = entry.opr;
      pair_d.opr1 = in_tok_i.opr;
    end
  end

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_send_o <= 1'b0;
      mm_vld     <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (take) begin
        // a stored or dropped token leaves the output empty
        out_send_o <= fire;
        if (!in_tok_i.uni) begin
          if (hit) begin
            mm_vld[slot] <= 1'b0;
          end else if (!mm_vld[slot]) begin
            mm_vld[slot] <= 1'b1;
          end else begin
            // slot held by another node or gen, token lost
            overflow_o <= 1'b1;
          end
        end
      end else if (out_ack_i) begin
        out_send_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && fire) begin
      out_pair_o <= pair_d;
    end
    if (store) begin
      mm_data[slot] <= '{node: in_tok_i.node, gen: in_tok_i.gen,
                         lr: in_tok_i.lr, opr: in_tok_i.opr};
    end
  end

endmodule

// File: rtl/instr_store.sv
`timescale 1ns/1ns
module instr_store (
  input  logic                      clk,
  input  logic                      cfg_we_i,
  input  logic [pe_pkg::NODE_W-1:0] cfg_addr_i,
  input  pe_pkg::instr_t            cfg_data_i,
  input  logic [pe_pkg::NODE_W-1:0] rd_node_i,
  output pe_pkg::instr_t            rd_instr_o
);

  localparam int DEPTH = 2 ** pe_pkg::NODE_W;

  // one instruction per node
  pe_pkg::instr_t prog_mem [DEPTH];

  // program load, only while the PE is idle
  always_ff @(posedge clk) begin
    if (cfg_we_i) begin
      prog_mem[cfg_addr_i] <= cfg_data_i;
    end
  end

  assign rd_instr_o = prog_mem[rd_node_i];

endmodule

// File: rtl/instr_fetch.sv
`timescale 1ns/1ns
module instr_fetch (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      in_send_i,
  input  pe_pkg::pair_t             in_pair_i,
  input  pe_pkg::instr_t            rd_instr_i,
  input  logic                      out_ack_i,
  output logic                      in_ack_o,
  output logic [pe_pkg::NODE_W-1:0] rd_node_o,
  output logic                      out_send_o,
  output pe_pkg::fetched_t          out_item_o
);

  logic take;

  // store lookup runs on the incoming pair
  assign rd_node_o = in_pair_i.node;

  assign in_ack_o = !out_send_o || out_ack_i;
  assign take     = in_send_i && in_ack_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_send_o <= 1'b0;
    end else if (take) begin
      out_send_o <= 1'b1;
    end else if (out_ack_i) begin
      out_send_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_item_o.pair  <= in_pair_i;
      out_item_o.instr <= rd_instr_i;
    end
  end

endmodule

// File: rtl/alu_exec.sv
`timescale 1ns/1ns
module alu_exec (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             in_send_i,
  input  pe_pkg::fetched_t in_item_i,
  input  logic             ext_ack_i,
  input  logic             loop_ack_i,
  output logic             in_ack_o,
  output logic             ext_send_o,
  output logic             loop_send_o,
  output pe_pkg::token_t   res_tok_o
);

  localparam int DATA_W = pe_pkg::DATA_W;
  localparam int IMM_W  = pe_pkg::IMM_W;

  pe_pkg::instr_t    ins;
  logic [DATA_W-1:0] opa;
  logic [DATA_W-1:0] opb;
  logic [DATA_W-1:0] res;
  logic              vld;
  logic              ext_q;
  logic              sel_ack;
  logic              take;

  assign ins = in_item_i.instr;
  assign opa = in_item_i.pair.opr0;
  // uni firing takes the sign-extended immediate as right operand
  assign opb = in_item_i.pair.uni ?
               {{(DATA_W-IMM_W){ins.imm[IMM_W-1]}}, ins.imm} :
               in_item_i.pair.opr1;

  always_comb begin
    case (ins.op)
      pe_pkg::OP_ADD: res = opa + opb;
      pe_pkg::OP_SUB: res = opa - opb;
      pe_pkg::OP_AND: res = opa & opb;
      pe_pkg::OP_OR:  res = opa | opb;
      pe_pkg::OP_XOR: res = opa ^ opb;
      // low half of the product
      pe_pkg::OP_MUL: res = opa * opb;
      pe_pkg::OP_LT:  res = {{(DATA_W-1){1'b0}}, $signed(opa) < $signed(opb)};
      default:        res = opa;
    endcase
  end

  //////////////////////////////////////////////////
  // result register and routing
  //////////////////////////////////////////////////

  assign ext_send_o  = vld && ext_q;
  assign loop_send_o = vld && !ext_q;

  // only the selected queue can drain us
  assign sel_ack  = ext_q ? ext_ack_i : loop_ack_i;
  assign in_ack_o = !vld || sel_ack;
  assign take     = in_send_i && in_ack_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld   <= 1'b0;
      ext_q <= 1'b0;
    end else if (take) begin
      vld   <= 1'b1;
      ext_q <= ins.ext;
    end else if (sel_ack) begin
      vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_tok_o <= '{node: ins.dest_node, gen: in_item_i.pair.gen, opr: res,
                     lr: ins.dest_lr, uni: ins.dest_uni};
    end
  end

endmodule

// File: rtl/token_queue.sv
`timescale 1ns/1ns
module token_queue #(
  parameter type payload_t = pe_pkg::token_t
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     wr_send_i,
  input  payload_t wr_data_i,
  input  logic     rd_ack_i,
  output logic     wr_ack_o,
  output logic     rd_send_o,
  output payload_t rd_data_o
);

  payload_t   q_mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] cnt;
  logic       push;
  logic       pop;

  // ack from count only, keeps the loopback ack path registered
  assign wr_ack_o  = (cnt != 2'd2);
  assign rd_send_o = (cnt != 2'd0);
  assign rd_data_o = q_mem[rd_ptr];

  assign push = wr_send_i && wr_ack_o;
  assign pop  = rd_send_o && rd_ack_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      cnt    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      cnt <= cnt + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= wr_data_i;
    end
  end

endmodule

// File: rtl/pe_core.sv
`timescale 1ns/1ns
module pe_core #(
  parameter int MM_ADDR_W = pe_pkg::MM_ADDR_W
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      in_send_i,
  input  pe_pkg::token_t            in_tok_i,
  input  logic                      out_ack_i,
  input  logic                      cfg_we_i,
  input  logic [pe_pkg::NODE_W-1:0] cfg_addr_i,
  input  pe_pkg::instr_t            cfg_data_i,
  output logic                      in_ack_o,
  output logic                      out_send_o,
  output pe_pkg::token_t            out_tok_o,
  output logic                      mm_overflow_o
);

  // merge to matcher
  logic                      mrg_send;
  logic                      mrg_ack;
  pe_pkg::token_t            mrg_tok;
  // matcher to fetch
  logic                      fire_send;
  logic                      fire_ack;
  pe_pkg::pair_t             fire_pair;
  // fetch to execute, plus store lookup
  logic                      ftc_send;
  logic                      ftc_ack;
  pe_pkg::fetched_t          ftc_item;
  logic [pe_pkg::NODE_W-1:0] rd_node;
  pe_pkg::instr_t            rd_instr;
  // execute to the two queues
  logic                      res_ext_send;
  logic                      res_loop_send;
  logic                      res_ext_ack;
  logic                      res_loop_ack;
  pe_pkg::token_t            res_tok;
  // loopback into merge
  logic                      loop_send;
  logic                      loop_ack;
  pe_pkg::token_t            loop_tok;

  token_merge u_merge (
    .clk, .rst_n_i,
    .ext_send_i(in_send_i), .ext_tok_i(in_tok_i),
    .loop_send_i(loop_send), .loop_tok_i(loop_tok), .out_ack_i(mrg_ack),
    .ext_ack_o(in_ack_o), .loop_ack_o(loop_ack),
    .out_send_o(mrg_send), .out_tok_o(mrg_tok)
  );

  firing_match #(.MM_ADDR_W(MM_ADDR_W)) u_match (
    .clk, .rst_n_i,
    .in_send_i(mrg_send), .in_tok_i(mrg_tok), .out_ack_i(fire_ack),
    .in_ack_o(mrg_ack), .out_send_o(fire_send), .out_pair_o(fire_pair),
    .overflow_o(mm_overflow_o)
  );

  instr_store u_store (
    .clk, .cfg_we_i, .cfg_addr_i, .cfg_data_i,
    .rd_node_i(rd_node), .rd_instr_o(rd_instr)
  );

  instr_fetch u_fetch (
    .clk, .rst_n_i,
    .in_send_i(fire_send), .in_pair_i(fire_pair), .rd_instr_i(rd_instr),
    .out_ack_i(ftc_ack), .in_ack_o(fire_ack), .rd_node_o(rd_node),
    .out_send_o(ftc_send), .out_item_o(ftc_item)
  );

  alu_exec u_exec (
    .clk, .rst_n_i,
    .in_send_i(ftc_send), .in_item_i(ftc_item),
    .ext_ack_i(res_ext_ack), .loop_ack_i(res_loop_ack), .in_ack_o(ftc_ack),
    .ext_send_o(res_ext_send), .loop_send_o(res_loop_send), .res_tok_o(res_tok)
  );

  token_queue #(.payload_t(pe_pkg::token_t)) u_out_q (
    .clk, .rst_n_i,
    .wr_send_i(res_ext_send), .wr_data_i(res_tok), .rd_ack_i(out_ack_i),
    .wr_ack_o(res_ext_ack), .rd_send_o(out_send_o), .rd_data_o(out_tok_o)
  );

  token_queue #(.payload_t(pe_pkg::token_t)) u_loop_q (
    .clk, .rst_n_i,
    .wr_send_i(res_loop_send), .wr_data_i(res_tok), .rd_ack_i(loop_ack),
    .wr_ack_o(res_loop_ack), .rd_send_o(loop_send), .rd_data_o(loop_tok)
  );

endmodule

// File: include/pe_tb_model.svh
`ifndef PE_TB_MODEL_SVH
`define PE_TB_MODEL_SVH

// copy of the program held in the instruction store
pe_pkg::instr_t prog [256];
// expected ICN output tokens, in no particular order
pe_pkg::token_t exp_q [$];

//////////////////////////////////////////////////
// reference ALU and PE model
//////////////////////////////////////////////////

function automatic logic [31:0] alu_model(input pe_pkg::opcode_e op,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
  logic [31:0] res;
  case (op)
    pe_pkg::OP_ADD: res = a + b;
    pe_pkg::OP_SUB: res = a - b;
    pe_pkg::OP_AND: res = a & b;
    pe_pkg::OP_OR:  res = a | b;
    pe_pkg::OP_XOR: res = a ^ b;
    pe_pkg::OP_MUL: res = a * b;
    pe_pkg::OP_LT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    default:        res = a;
  endcase
  return res;
endfunction

// follows loopback hops until an instruction sends to the ICN
function automatic pe_pkg::token_t expect_output(input logic [7:0]  node,
                                                 input logic [11:0] gen,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b,
                                                 input logic        uni);
  pe_pkg::instr_t ins;
  pe_pkg::token_t tok;
  logic [31:0]    rhs;
  for (int hop = 0; hop < 4; hop++) begin
    ins = prog[node];
    // single operand takes the sign-extended immediate
    rhs = uni ? {{16{ins.imm[15]}}, ins.imm} : b;
    tok.node = ins.dest_node;
    tok.gen  = gen;
    tok.opr  = alu_model(ins.op, a, rhs);
    tok.lr   = ins.dest_lr;
    tok.uni  = ins.dest_uni;
    if (ins.ext) begin
      break;
    end
    // loop target is a uni node
    node = ins.dest_node;
    a    = tok.opr;
    uni  = 1'b1;
  end
  return tok;
endfunction

//////////////////////////////////////////////////
// scoreboard
//////////////////////////////////////////////////

function automatic void add_expected(input pe_pkg::token_t tok);
  exp_q.push_back(tok);
endfunction

// outputs get reordered, so search the whole list
function automatic bit remove_expected(input pe_pkg::token_t tok);
  for (int i = 0; i < exp_q.size(); i++) begin
    if (exp_q[i] == tok) begin
      exp_q.delete(i);
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

`endif

// File: dv/pe_tb.sv
`timescale 1ns/1ns
module pe_tb;

  localparam int WAIT_LIMIT  = 500;
  localparam int DRAIN_LIMIT = 3000;
  // node A loops its result to node B, which sends it out
  localparam int NODE_A = 128;
  localparam int NODE_B = 129;

  logic                      clk;
  logic                      rst_n_i;
  logic                      in_send_i;
  pe_pkg::token_t            in_tok_i;
  logic                      out_ack_i;
  logic                      cfg_we_i;
  logic [pe_pkg::NODE_W-1:0] cfg_addr_i;
  pe_pkg::instr_t            cfg_data_i;
  logic                      in_ack_o;
  logic                      out_send_o;
  pe_pkg::token_t            out_tok_o;
  logic                      mm_overflow_o;

  integer seed;
  bit     bp_mode;

  `include "pe_tb_model.svh"

  pe_core #(.MM_ADDR_W(4)) dut_i (
    .clk, .rst_n_i, .in_send_i, .in_tok_i, .out_ack_i,
    .cfg_we_i, .cfg_addr_i, .cfg_data_i,
    .in_ack_o, .out_send_o, .out_tok_o, .mm_overflow_o
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_on_error($sformatf("MISMATCH at %0t ns: %s", $time, msg));
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic send_token(input pe_pkg::token_t tok);
    int waited;
    waited = 0;
    in_tok_i  = tok;
    in_send_i = 1'b1;
    @(negedge clk);
    while (!in_ack_o) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_on_error("timeout: the PE never acknowledged a token on its ICN input");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_send_i = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_LIMIT) begin
        stop_on_error($sformatf("timeout: the %s never all left the PE", what));
      end
    end
    #1;
  endtask

  task automatic load_program();
    pe_pkg::instr_t ins;
    logic [31:0]    r;
    cfg_we_i = 1'b1;
    for (int n = 0; n < 256; n++) begin
      r = next_random();
      ins.op        = pe_pkg::opcode_e'(r[2:0]);
      ins.dest_node = r[10:3];
      ins.dest_lr   = r[11];
      ins.dest_uni  = r[12];
      ins.ext       = 1'b1;
      ins.imm       = r[31:16];
      if (n == NODE_A) begin
        ins.dest_node = 8'(NODE_B);
        ins.dest_uni  = 1'b1;
        ins.ext       = 1'b0;
      end
      prog[n]    = ins;
      cfg_addr_i = 8'(n);
      cfg_data_i = ins;
      @(posedge clk);
      #1;
    end
    cfg_we_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // uni tokens to plain nodes, to the loop chain, or a random mix
  task automatic send_uni_tokens(input int count, input bit to_chain, input bit mix);
    pe_pkg::token_t tok;
    logic [31:0]    r;
    bit             chain;
    for (int i = 0; i < count; i++) begin
      r = next_random();
      chain    = mix ? r[19] : to_chain;
      tok.node = chain ? 8'(NODE_A) : {2'b00, r[5:0]};
      tok.gen  = r[17:6];
      tok.lr   = r[18];
      tok.uni  = 1'b1;
      tok.opr  = next_random();
      add_expected(expect_output(tok.node, tok.gen, tok.opr, 32'd0, 1'b1));
      send_token(tok);
    end
  endtask

  task automatic send_operand_pairs(input int count);
    pe_pkg::token_t ops [32];
    int             order [32];
    bit             opened [16];
    logic [31:0]    r;
    int             j;
    int             tmp;
    int             p;
    for (int k = 0; k < count; k++) begin
      r = next_random();
      // low gen bits differ so each pair owns a slot
      ops[2*k].node    = {2'b00, r[5:0]};
      ops[2*k].gen     = {r[13:6], 4'(k)};
      ops[2*k].lr      = 1'b0;
      ops[2*k].uni     = 1'b0;
      ops[2*k].opr     = next_random();
      ops[2*k+1]       = ops[2*k];
      ops[2*k+1].lr    = 1'b1;
      ops[2*k+1].opr   = next_random();
      order[2*k]       = 2 * k;
      order[2*k+1]     = 2 * k + 1;
      opened[k]        = 1'b0;
    end
    for (int i = 2 * count - 1; i > 0; i--) begin
      r = next_random();
      j = int'(r[15:0]) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < 2 * count; k++) begin
      p = order[k] / 2;
      // the second operand of a pair is the one that fires
      if (opened[p]) begin
        add_expected(expect_output(ops[2*p].node, ops[2*p].gen, ops[2*p].opr,
                                   ops[2*p+1].opr, 1'b0));
      end
      opened[p] = 1'b1;
      send_token(ops[order[k]]);
      if (k == 0) begin
        // lone operand waits in the matching memory and makes no output
        repeat (12) @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic check_overflow();
    pe_pkg::token_t first;
    pe_pkg::token_t other;
    pe_pkg::token_t partner;
    int             waited;
    assert (mm_overflow_o === 1'b0)
      else report_mismatch("mm_overflow_o high before any slot conflict");
    first.node = 8'h10;
    first.gen  = {8'h5a, 4'h3};
    first.opr  = next_random();
    first.lr   = 1'b0;
    first.uni  = 1'b0;
    other      = first;
    other.node = 8'h11;
    other.gen  = {8'ha5, 4'h3};
    send_token(first);
    send_token(other);
    waited = 0;
    @(negedge clk);
    while (mm_overflow_o !== 1'b1) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_on_error("timeout: mm_overflow_o never rose after a slot conflict");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    partner     = first;
    partner.lr  = 1'b1;
    partner.opr = next_random();
    add_expected(expect_output(first.node, first.gen, first.opr, partner.opr, 1'b0));
    send_token(partner);
    wait_drain("overflow partner result");
    assert (mm_overflow_o === 1'b1)
      else report_mismatch("mm_overflow_o did not stay high");
  endtask

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////

  initial begin : ack_driver
    logic [31:0] r;
    int          stall_left;
    out_ack_i  = 1'b1;
    stall_left = 0;
    forever begin
      @(posedge clk);
      // next stall state is picked on the edge and driven 1 ns later
      if (stall_left > 0) begin
        stall_left--;
      end else if (bp_mode) begin
        r = next_random();
        // roughly one stall start in eight cycles
        if (r[2:0] == 3'd0) begin
          stall_left = 2 + int'(r[7:4]);
        end
      end
      #1;
      out_ack_i = (stall_left == 0);
    end
  end

  // transfer happens at the next rising edge
  always @(negedge clk) begin : out_monitor
    bit found;
    if (rst_n_i && out_send_o && out_ack_i) begin
      found = remove_expected(out_tok_o);
      assert (found)
        else report_mismatch($sformatf(
          "unexpected output node %h gen %h opr %h lr %b uni %b",
          out_tok_o.node, out_tok_o.gen, out_tok_o.opr, out_tok_o.lr, out_tok_o.uni));
    end
  end

  initial begin
    seed       = 32'h45ebc8e2;
    bp_mode    = 1'b0;
    rst_n_i    = 1'b0;
    in_send_i  = 1'b0;
    in_tok_i   = '0;
    cfg_we_i   = 1'b0;
    cfg_addr_i = '0;
    cfg_data_i = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    assert (out_send_o === 1'b0 && mm_overflow_o === 1'b0)
      else report_mismatch("send or overflow output high after reset");
    load_program();
    send_uni_tokens(40, 1'b0, 1'b0);
    wait_drain("uni token results");
    send_operand_pairs(12);
    wait_drain("operand pair results");
    send_uni_tokens(24, 1'b1, 1'b0);
    wait_drain("loopback chain results");
    bp_mode = 1'b1;
    send_uni_tokens(80, 1'b0, 1'b1);
    wait_drain("back-pressure results");
    bp_mode = 1'b0;
    check_overflow();
    // quiet stretch so a late extra token is still caught
    repeat (20) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d expected tokens never left the PE", exp_q.size()));
    end
  end

endmodule

// File: sources.f
+incdir+include
rtl/pe_pkg.sv
rtl/token_merge.sv
rtl/firing_match.sv
rtl/instr_store.sv
rtl/instr_fetch.sv
rtl/alu_exec.sv
rtl/token_queue.sv
rtl/pe_core.sv
dv/pe_tb.sv

// File: run.sh
#!/bin/sh
# build and run the PE testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module pe_tb \
  -o pe_tb_sim

./obj_dir/pe_tb_sim
